/* src/cdc_consts.svh */
// Shared constants for the fast-to-slow configuration bridge
// Included by the packages and by any RTL that sizes storage or picks addresses
`ifndef CDC_CONSTS_SVH
`define CDC_CONSTS_SVH

// --------------------
// Synchronizer
`define CDC_SYNC_STAGES 2        // Flops per crossing

// --------------------
// Register bank
`define CDC_REG_W       32       // Bank word width
`define CDC_BANK_DEPTH  4        // Entries, last one spare

// Bank addresses, one per channel
`define CDC_ADDR_CFG    2'd0
`define CDC_ADDR_THRESH 2'd1
`define CDC_ADDR_MASK   2'd2

`endif

/* src/cdc_payload_pkg.sv */
// Payload types carried from the fast control domain by the sync channels
// Import into any module that handles the raw configuration values
`default_nettype none

package cdc_payload_pkg;

    // --------------------
    // Mode configuration word, 8 bits
    typedef struct packed {
        logic       en;      // Block enable
        logic [2:0] mode;    // Operating mode select
        logic [3:0] gain;    // Gain step
    } mode_cfg_t;

    // --------------------
    // Scalar payloads
    typedef logic [15:0] thresh_t;   // Detection threshold
    typedef logic [7:0]  irq_mask_t; // One bit per interrupt source

    // All three fit in the low bits of a bank word
    // and are zero-extended on the way in

endpackage : cdc_payload_pkg

`default_nettype wire

/* src/regbank_pkg.sv */
// Types for the slow-domain register bank side of the bridge
// Covers the single write bus and the channel/address index
`default_nettype none

`include "cdc_consts.svh"

package regbank_pkg;

    // --------------------
    // Channel number, also used directly as bank address
    typedef logic [1:0] chan_idx_t;

    // --------------------
    // Bank write bus driven by the arbiter, 35 bits
    typedef struct packed {
        logic                  we;   // Write strobe
        chan_idx_t             addr; // Target entry
        logic [`CDC_REG_W-1:0] data; // Zero-extended payload
    } bank_wr_t;

    // Idle bus value
    localparam bank_wr_t BANK_WR_IDLE = '{we: 1'b0, addr: '0, data: '0};

endpackage : regbank_pkg

`default_nettype wire

/* src/bit_sync.sv */
// Flop chain synchronizer into the destination clock domain
// Use for single levels or for a data word that is held stable while sampled
`default_nettype none

`include "cdc_consts.svh"

module bit_sync #(
    parameter int N = 1                  // Width of the crossing
) (
    input  wire logic         clk,       // Destination clock
    input  wire logic         rstn,      // Destination reset, active low
    input  wire logic [N-1:0] async_in,  // Source domain signal
    output logic      [N-1:0] sync_out   // Resynchronized copy
);

    // --------------------
    // Stage registers, index 0 takes the raw input
    logic [N-1:0] stage_q [`CDC_SYNC_STAGES];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `CDC_SYNC_STAGES; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= async_in;              // First flop may go metastable
            for (int i = 1; i < `CDC_SYNC_STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];      // Settling stages
            end
        end
    end

    assign sync_out = stage_q[`CDC_SYNC_STAGES-1];

endmodule : bit_sync

`default_nettype wire

/* src/fast_to_slow_sync.sv */
// Four-phase req/ack channel moving one payload word from fast to slow clock
// Changes during a transfer are coalesced, the newest stable value wins
// slow_update pulses for one slow cycle each time slow_data is reloaded
`default_nettype none

module fast_to_slow_sync #(
    parameter type payload_t = logic     // Carried value
) (
    // Fast side
    input  wire logic     fast_clk,
    input  wire logic     fast_rstn,
    input  wire payload_t fast_data,     // Live value from the source
    // Slow side
    input  wire logic     slow_clk,
    input  wire logic     slow_rstn,
    output payload_t      slow_data,     // Last delivered value
    output logic          slow_update    // One-cycle reload strobe
);

    localparam int W = $bits(payload_t);

    // --------------------
    // Handshake and data nets
    payload_t fast_held;       // Copy frozen while req is high
    logic     fast_req;
    logic     fast_ack;        // slow_ack seen in fast domain
    logic     slow_req;        // fast_req seen in slow domain
    logic     slow_ack;
    payload_t slow_sync_data;  // fast_held after the flop chain

    // --------------------
    // Fast domain, capture and request
    always_ff @(posedge fast_clk or negedge fast_rstn) begin
        if (!fast_rstn) begin
            fast_req  <= 1'b0;
            fast_held <= '0;
        end else if (!fast_req && !fast_ack && fast_held != fast_data) begin
            // Idle and the source moved, start a new transfer
            fast_req  <= 1'b1;
            fast_held <= fast_data;
        end else if (fast_req && fast_ack) begin
            fast_req  <= 1'b0;                   // Slow side has the data
        end
    end

    // --------------------
    // Slow domain, acknowledge and load
    always_ff @(posedge slow_clk or negedge slow_rstn) begin
        if (!slow_rstn) begin
            slow_ack    <= 1'b0;
            slow_data   <= '0;
            slow_update <= 1'b0;
        end else begin
            slow_update <= 1'b0;
            if (slow_req && !slow_ack) begin
                slow_ack    <= 1'b1;
                slow_data   <= slow_sync_data;   // Stable, req holds it
                slow_update <= 1'b1;             // Single pulse, ack blocks a repeat
            end else if (!slow_req && slow_ack) begin
                slow_ack <= 1'b0;                // Return to zero
            end
        end
    end

    // --------------------
    // Crossings
    bit_sync #(.N(1)) req_sync (
        .clk      (slow_clk),
        .rstn     (slow_rstn),
        .async_in (fast_req),
        .sync_out (slow_req)
    );

    bit_sync #(.N(1)) ack_sync (
        .clk      (fast_clk),
        .rstn     (fast_rstn),
        .async_in (slow_ack),
        .sync_out (fast_ack)
    );

    // Word changes only while req is low, so no bit can tear
    bit_sync #(.N(W)) data_sync (
        .clk      (slow_clk),
        .rstn     (slow_rstn),
        .async_in (fast_held),
        .sync_out (slow_sync_data)
    );

endmodule : fast_to_slow_sync

`default_nettype wire

/* src/write_arbiter.sv */
// Round-robin owner of the bank write bus for the three channels
// Each channel gets a pending flag and a newest-value slot
`default_nettype none

`include "cdc_consts.svh"

module write_arbiter
    import regbank_pkg::*;
(
    input  wire logic                        slow_clk,
    input  wire logic                        slow_rstn,
    input  wire logic [2:0]                  upd,       // Channel reload pulses
    input  wire logic [2:0][`CDC_REG_W-1:0]  upd_data,  // Zero-extended payloads
    output bank_wr_t                         bank_wr
);

    localparam int NUM_CHAN = 3;

    // --------------------
    // State
    logic [NUM_CHAN-1:0]                 pending;
    logic [NUM_CHAN-1:0][`CDC_REG_W-1:0] data_q;       // Newest value per channel
    chan_idx_t                           last_grant;

    logic      gnt_valid;
    chan_idx_t gnt_idx;

    // Channel number to bank address
    function automatic chan_idx_t chan_addr(input chan_idx_t ch);
        case (ch)
            2'd0:    return `CDC_ADDR_CFG;
            2'd1:    return `CDC_ADDR_THRESH;
            default: return `CDC_ADDR_MASK;
        endcase
    endfunction

    // --------------------
    // Grant, search starts just after the last winner
    always_comb begin
        int unsigned idx;
        gnt_valid = 1'b0;
        gnt_idx   = '0;
        for (int off = 1; off <= NUM_CHAN; off++) begin
            idx = (int'(last_grant) + off) % NUM_CHAN;
            if (!gnt_valid && pending[idx]) begin
                gnt_valid = 1'b1;
                gnt_idx   = chan_idx_t'(idx);
            end
        end
    end

    // Bus follows the grant in the same cycle
    always_comb begin
        bank_wr.we   = gnt_valid;
        bank_wr.addr = chan_addr(gnt_idx);
        bank_wr.data = data_q[gnt_idx];
    end

    // --------------------
    // Flags and slots
    always_ff @(posedge slow_clk or negedge slow_rstn) begin
        if (!slow_rstn) begin
            pending    <= '0;
            data_q     <= '0;
            last_grant <= chan_idx_t'(NUM_CHAN - 1);  // Channel 0 first
        end else begin
            if (gnt_valid) begin
                pending[gnt_idx] <= 1'b0;
                last_grant       <= gnt_idx;
            end
            for (int i = 0; i < NUM_CHAN; i++) begin
                if (upd[i]) begin
                    pending[i] <= 1'b1;          // Fresh update beats a clear
                    data_q[i]  <= upd_data[i];   // Overwrite stale value
                end
            end
        end
    end

endmodule : write_arbiter

`default_nettype wire

/* src/slow_reg_bank.sv */
// Slow-domain configuration registers seen by peripheral logic
// One write port from the arbiter, one combinational read port
`default_nettype none

`include "cdc_consts.svh"

module slow_reg_bank
    import regbank_pkg::*;
(
    input  wire logic            slow_clk,
    input  wire logic            slow_rstn,
    input  wire bank_wr_t        bank_wr,    // From the arbiter
    input  wire chan_idx_t       rd_addr,
    output logic [`CDC_REG_W-1:0] rd_data
);

    // --------------------
    // Storage
    logic [`CDC_REG_W-1:0] regs_q [`CDC_BANK_DEPTH];

    always_ff @(posedge slow_clk or negedge slow_rstn) begin
        if (!slow_rstn) begin
            for (int i = 0; i < `CDC_BANK_DEPTH; i++) begin
                regs_q[i] <= '0;             // Bank reads zero out of reset
            end
        end else if (bank_wr.we) begin
            regs_q[bank_wr.addr] <= bank_wr.data;
        end
    end

    // --------------------
    // Read port
    // Straight from the registers, so a write shows the next cycle
    always_comb begin
        rd_data = regs_q[rd_addr];
    end

endmodule : slow_reg_bank

`default_nettype wire

/* src/cdc_bridge_top.sv */
// Top of the fast-to-slow configuration bridge
// Three sync channels feed a round-robin arbiter that writes the slow register bank
`default_nettype none

`include "cdc_consts.svh"

module cdc_bridge_top
    import cdc_payload_pkg::*;
    import regbank_pkg::*;
(
    // Fast control domain
    input  wire logic             fast_clk,
    input  wire logic             fast_rstn,
    input  wire mode_cfg_t        cfg,
    input  wire thresh_t          thresh,
    input  wire irq_mask_t        irq_mask,
    // Slow peripheral domain
    input  wire logic             slow_clk,
    input  wire logic             slow_rstn,
    input  wire chan_idx_t        rd_addr,
    output logic [`CDC_REG_W-1:0] rd_data
);

    // --------------------
    // Slow-side channel outputs
    mode_cfg_t cfg_slow;
    thresh_t   thresh_slow;
    irq_mask_t mask_slow;
    logic      cfg_upd;
    logic      thresh_upd;
    logic      mask_upd;
    bank_wr_t  bank_wr;     // Arbiter to bank

    // --------------------
    // Channels
    fast_to_slow_sync #(.payload_t(mode_cfg_t)) u_cfg_sync (
        .fast_clk    (fast_clk),
        .fast_rstn   (fast_rstn),
        .fast_data   (cfg),
        .slow_clk    (slow_clk),
        .slow_rstn   (slow_rstn),
        .slow_data   (cfg_slow),
        .slow_update (cfg_upd)
    );

    fast_to_slow_sync #(.payload_t(thresh_t)) u_thresh_sync (
        .fast_clk    (fast_clk),
        .fast_rstn   (fast_rstn),
        .fast_data   (thresh),
        .slow_clk    (slow_clk),
        .slow_rstn   (slow_rstn),
        .slow_data   (thresh_slow),
        .slow_update (thresh_upd)
    );

    fast_to_slow_sync #(.payload_t(irq_mask_t)) u_mask_sync (
        .fast_clk    (fast_clk),
        .fast_rstn   (fast_rstn),
        .fast_data   (irq_mask),
        .slow_clk    (slow_clk),
        .slow_rstn   (slow_rstn),
        .slow_data   (mask_slow),
        .slow_update (mask_upd)
    );

    // --------------------
    // Arbiter, index order matches the bank address map
    write_arbiter u_arb (
        .slow_clk  (slow_clk),
        .slow_rstn (slow_rstn),
        .upd       ({mask_upd, thresh_upd, cfg_upd}),
        .upd_data  ({{{(`CDC_REG_W-$bits(irq_mask_t)){1'b0}}, mask_slow},
                     {{(`CDC_REG_W-$bits(thresh_t)){1'b0}}, thresh_slow},
                     {{(`CDC_REG_W-$bits(mode_cfg_t)){1'b0}}, cfg_slow}}),
        .bank_wr   (bank_wr)
    );

    slow_reg_bank u_bank (
        .slow_clk  (slow_clk),
        .slow_rstn (slow_rstn),
        .bank_wr   (bank_wr),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

endmodule : cdc_bridge_top

`default_nettype wire

/* sim/cdc_bridge_assert.sv */
// Concurrent protocol checks for the bridge, bound into cdc_bridge_top
// Covers the req/ack handshake, the update strobe width and the bank write bus
`default_nettype none

module cdc_bridge_assert
    import regbank_pkg::*;
(
    input wire logic       fast_clk,
    input wire logic       fast_rstn,
    input wire logic       slow_clk,
    input wire logic       slow_rstn,
    input wire logic [2:0] req,        // Fast-side requests, cfg in bit 0
    input wire logic [2:0] req_acked,  // ack seen back in the fast domain
    input wire logic [2:0] upd,        // slow_update strobes
    input wire logic [2:0] pending,    // Arbiter pending flags
    input wire bank_wr_t   bank_wr
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;       // Failed assertions so far

    // --------------------
    // Per-channel handshake
    for (genvar i = 0; i < 3; i++) begin : g_chan
        req_hold_a: assert property (@(posedge fast_clk) disable iff (!fast_rstn)
            req[i] && !req_acked[i] |=> req[i])
            else begin
                $error("req on channel %0d dropped before its ack returned", i);
                fail_count++;
            end

        upd_pulse_a: assert property (@(posedge slow_clk) disable iff (!slow_rstn)
            upd[i] |=> !upd[i])
            else begin
                $error("slow_update on channel %0d held longer than one cycle", i);
                fail_count++;
            end
    end

    // --------------------
    // Write bus
    // A flag may only clear for the single channel written in the cycle before
    one_grant_a: assert property (@(posedge slow_clk) disable iff (!slow_rstn)
        ($past(pending) & ~pending) == 3'b000 ||
        ($past(bank_wr.we) &&
         ($past(pending) & ~pending) == (3'b001 << $past(bank_wr.addr))))
        else begin
            $error("pending flags cleared without a matching single bank write");
            fail_count++;
        end

    no_spare_write_a: assert property (@(posedge slow_clk) disable iff (!slow_rstn)
        bank_wr.we |-> bank_wr.addr != 2'd3)
        else begin
            $error("bank write aimed at the spare entry 3");
            fail_count++;
        end

endmodule : cdc_bridge_assert

bind cdc_bridge_top cdc_bridge_assert u_assert (
    .fast_clk  (fast_clk),
    .fast_rstn (fast_rstn),
    .slow_clk  (slow_clk),
    .slow_rstn (slow_rstn),
    .req       ({u_mask_sync.fast_req, u_thresh_sync.fast_req, u_cfg_sync.fast_req}),
    .req_acked ({u_mask_sync.fast_ack, u_thresh_sync.fast_ack, u_cfg_sync.fast_ack}),
    .upd       ({mask_upd, thresh_upd, cfg_upd}),
    .pending   (u_arb.pending),
    .bank_wr   (bank_wr)
);

`default_nettype wire

/* sim/cdc_bridge_tb.sv */
// Testbench for the fast-to-slow configuration bridge
// Stimulus and expected bank contents come from sim/cdc_bridge_tests.txt
// Run from the project root so the data file path resolves
`default_nettype none

`include "cdc_consts.svh"

module cdc_bridge_tb
    import cdc_payload_pkg::*;
    import regbank_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    FAST_PERIOD   = 20;
    localparam int    SLOW_PERIOD   = 70;
    localparam int    SETTLE_CYCLES = 40;     // Slow cycles before the bank is read
    localparam int    WDOG_PER_TEST = 60;     // Slow cycles of budget per line
    localparam string TEST_FILE     = "sim/cdc_bridge_tests.txt";

    // One line of the data file
    typedef struct packed {
        logic                  settle;     // Wait and check after driving
        mode_cfg_t             cfg;
        thresh_t               thresh;
        irq_mask_t             mask;
        logic [`CDC_REG_W-1:0] exp_cfg;
        logic [`CDC_REG_W-1:0] exp_thresh;
        logic [`CDC_REG_W-1:0] exp_mask;
    } test_vec_t;

    // --------------------
    // DUT signals
    logic                  fast_clk;
    logic                  fast_rstn;
    logic                  slow_clk;
    logic                  slow_rstn;
    mode_cfg_t             cfg;
    thresh_t               thresh;
    irq_mask_t             irq_mask;
    chan_idx_t             rd_addr;
    logic [`CDC_REG_W-1:0] rd_data;

    test_vec_t vecs[$];
    string     names[$];
    int        n_tests = 0;
    int        errors  = 0;
    int        checks  = 0;

    cdc_bridge_top DUT (
        .fast_clk  (fast_clk),
        .fast_rstn (fast_rstn),
        .cfg       (cfg),
        .thresh    (thresh),
        .irq_mask  (irq_mask),
        .slow_clk  (slow_clk),
        .slow_rstn (slow_rstn),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    // --------------------
    // Clocks, unrelated periods
    initial begin
        fast_clk = 1'b0;
        forever #(FAST_PERIOD / 2) fast_clk = ~fast_clk;
    end

    initial begin
        slow_clk = 1'b0;
        forever #(SLOW_PERIOD / 2) slow_clk = ~slow_clk;
    end

    // Reads every non-comment line into vecs and names
    task automatic load_tests(output bit ok);
        int          fd;
        int          cnt;
        string       line;
        string       name;
        test_vec_t   v;
        logic [31:0] f_settle, f_cfg, f_thr, f_mask, f_e0, f_e1, f_e2;
        ok = 1'b0;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the test file %s", TEST_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line[0] == "#" || line[0] == "\n") continue;
                cnt = $sscanf(line, "%s %h %h %h %h %h %h %h", name, f_settle,
                              f_cfg, f_thr, f_mask, f_e0, f_e1, f_e2);
                if (cnt != 8) begin
                    $display("Malformed line in the test file: %s", line);
                    errors++;
                end else begin
                    v.settle     = f_settle[0];
                    v.cfg        = mode_cfg_t'(f_cfg[7:0]);
                    v.thresh     = thresh_t'(f_thr[15:0]);
                    v.mask       = irq_mask_t'(f_mask[7:0]);
                    v.exp_cfg    = f_e0;
                    v.exp_thresh = f_e1;
                    v.exp_mask   = f_e2;
                    vecs.push_back(v);
                    names.push_back(name);
                end
            end
            $fclose(fd);
            n_tests = vecs.size();
            ok      = (n_tests > 0);
            if (n_tests == 0) $display("The test file %s holds no tests", TEST_FILE);
        end
    endtask

    // Fast-side inputs change on a fast rising edge
    task automatic drive_inputs(input test_vec_t v);
        @(posedge fast_clk);
        cfg      <= v.cfg;
        thresh   <= v.thresh;
        irq_mask <= v.mask;
    endtask

    // Address set on a slow rising edge, data sampled mid-cycle
    task automatic check_reg(input string name, input chan_idx_t addr,
                             input logic [`CDC_REG_W-1:0] expected);
        logic [`CDC_REG_W-1:0] actual;
        @(posedge slow_clk);
        rd_addr <= addr;
        @(negedge slow_clk);
        actual = rd_data;
        checks++;
        assert (actual === expected) else begin
            $display("ERROR %s reg %0d: expected %08h, actual %08h",
                     name, addr, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bank(input string name, input test_vec_t v);
        check_reg(name, `CDC_ADDR_CFG,    v.exp_cfg);
        check_reg(name, `CDC_ADDR_THRESH, v.exp_thresh);
        check_reg(name, `CDC_ADDR_MASK,   v.exp_mask);
        check_reg(name, 2'd3, '0);               // Spare entry never written
    endtask

    // --------------------
    // Main sequence
    initial begin
        bit loaded;
        cfg       = '0;
        thresh    = '0;
        irq_mask  = '0;
        rd_addr   = '0;
        fast_rstn = 1'b0;
        slow_rstn = 1'b0;
        load_tests(loaded);
        if (!loaded) begin
            $display("Simulation failed");
            $finish;
        end else begin
            fork                                 // Each domain leaves reset on its own
                begin
                    repeat (3) @(posedge fast_clk);
                    fast_rstn <= 1'b1;
                end
                begin
                    repeat (3) @(posedge slow_clk);
                    slow_rstn <= 1'b1;
                end
            join
            foreach (vecs[i]) begin
                drive_inputs(vecs[i]);
                if (vecs[i].settle) begin
                    repeat (SETTLE_CYCLES) @(posedge slow_clk);
                    check_bank(names[i], vecs[i]);
                end
            end
            $display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                     n_tests, checks, errors, DUT.u_assert.fail_count);
            if (errors == 0 && DUT.u_assert.fail_count == 0)
                $display("Simulation passed");
            else
                $display("Simulation failed");
            $finish;
        end
    end

    // --------------------
    // Watchdog, budget scales with the number of lines
    initial begin
        wait (n_tests > 0);
        #(n_tests * WDOG_PER_TEST * SLOW_PERIOD);
        $display("Timeout: the tests did not finish within %0d slow cycles",
                 n_tests * WDOG_PER_TEST);
        $display("Simulation failed");
        $finish;
    end

endmodule : cdc_bridge_tb

`default_nettype wire

/* sim/cdc_bridge_tests.txt */
# Columns: name settle cfg thresh irq_mask exp_cfg exp_thresh exp_mask, all hex after the name
# settle 1 waits out the settling window and reads the bank, 0 drives the next line one fast cycle later
reset_zero     1 00 0000 00 00000000 00000000 00000000
cfg_only       1 a5 0000 00 000000a5 00000000 00000000
thresh_only    1 a5 beef 00 000000a5 0000beef 00000000
mask_only      1 a5 beef 3c 000000a5 0000beef 0000003c
all_three      1 ff ffff ff 000000ff 0000ffff 000000ff
all_three_alt  1 81 8001 42 00000081 00008001 00000042
thr_burst_0    0 81 0010 42 00000000 00000000 00000000
thr_burst_1    0 81 0011 42 00000000 00000000 00000000
thr_burst_2    0 81 0012 42 00000000 00000000 00000000
thr_burst_3    0 81 0013 42 00000000 00000000 00000000
thr_burst_4    0 81 0014 42 00000000 00000000 00000000
thr_burst_5    0 81 0015 42 00000000 00000000 00000000
thr_burst_end  1 81 0016 42 00000081 00000016 00000042
cfg_burst_0    0 01 0016 42 00000000 00000000 00000000
cfg_burst_1    0 02 0016 42 00000000 00000000 00000000
cfg_burst_2    0 03 0016 42 00000000 00000000 00000000
cfg_burst_end  1 7e 0016 42 0000007e 00000016 00000042
same_again     1 7e 0016 42 0000007e 00000016 00000042
new_after_same 1 7e 0016 99 0000007e 00000016 00000099
mask_clear     1 7e 0016 00 0000007e 00000016 00000000
thresh_top_bit 1 7e 8000 00 0000007e 00008000 00000000
all_back_zero  1 00 0000 00 00000000 00000000 00000000

/* compile.f */
+incdir+src
src/cdc_payload_pkg.sv
src/regbank_pkg.sv
src/bit_sync.sv
src/fast_to_slow_sync.sv
src/write_arbiter.sv
src/slow_reg_bank.sv
src/cdc_bridge_top.sv
sim/cdc_bridge_assert.sv
sim/cdc_bridge_tb.sv

/* Bender.yml */
package:
  name: cdc_bridge

sources:
  - include_dirs:
      - src
    files:
      - src/cdc_payload_pkg.sv
      - src/regbank_pkg.sv
      - src/bit_sync.sv
      - src/fast_to_slow_sync.sv
      - src/write_arbiter.sv
      - src/slow_reg_bank.sv
      - src/cdc_bridge_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/cdc_bridge_assert.sv
      - sim/cdc_bridge_tb.sv
